// File: rtl/ctx_cnt_pkg.sv
`default_nettype none

// shared constants for the per-context usage counter
// nothing in here depends on a module parameter, so the package stays
// free of types and only carries plain values
package ctx_cnt_pkg;

   // the operation select is a one-hot word with bit 0 on the left,
   // the same ordering the arbiter uses for its priority
   localparam int op_w = 3;

   // bit positions inside the one-hot select
   // these are indices into the select, never values to compare against
   localparam int op_inc = 0;
   localparam int op_rst = 1;
   localparam int op_dec = 2;

   // the arbiter priority follows the index order above, so increment
   // beats reset and reset beats decrement

   // default context id width, giving a table of 16 contexts
   localparam int def_id_width = 4;

   // default counter width in bits
   localparam int def_cnt_width = 8;

   // a counter saturates at the limit input, which is at most
   // 2**def_cnt_width - 1 with the defaults above

endpackage : ctx_cnt_pkg

`default_nettype wire

// File: rtl/ctx_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one arbitrated request travelling from the arbiter to the update stage
// a transfer happens on a cycle where valid and ready are both high
interface ctx_req_if #(
   parameter int id_width = ctx_cnt_pkg::def_id_width
);
   import ctx_cnt_pkg::*;

   // the arbiter holds valid until ready is seen
   logic                valid;
   logic                ready;

   // one-hot operation select, indexed by op_inc, op_rst and op_dec
   logic [0:op_w-1]     sel;

   // context id the operation works on
   logic [0:id_width-1] id;

   // only ever set together with the increment bit of sel
   logic                frc_oflw;

   // the arbiter side drives the request and watches ready
   modport src (output valid, output sel, output id, output frc_oflw, input ready);

   // the update stage takes the request and drives ready
   modport dst (input valid, input sel, input id, input frc_oflw, output ready);

endinterface : ctx_req_if

`default_nettype wire

// File: rtl/ctx_req_arb.sv
`timescale 1ns/1ps
`default_nettype none

// front end of the counter pipeline
// increment and reset requests are caught in one-entry latches, repeated
// resets are filtered against a first-use table, and a fixed priority
// picks one request per transaction with a dead cycle after each transfer
module ctx_req_arb #(
   parameter int id_width = ctx_cnt_pkg::def_id_width
) (
   input  wire                clk,
   input  wire                i_rst_n,

   input  wire                i_rst_v,
   input  wire [0:id_width-1] i_rst_id,
   output logic               o_rst_ack,

   input  wire                i_inc_v,
   input  wire [0:id_width-1] i_inc_id,
   input  wire                i_inc_frc_oflw,
   output logic               o_inc_rdy,

   input  wire                i_dec_v,
   input  wire [0:id_width-1] i_dec_id,
   output logic               o_dec_r,

   ctx_req_if.src             o_req
);
   import ctx_cnt_pkg::*;

   localparam int n_ctx = 2 ** id_width;

   // increment latch, one entry deep
   logic                inc_v_q;
   logic [0:id_width-1] inc_id_q;
   logic                inc_frc_q;

   // reset latch, one entry deep
   logic                rst_v_q;
   logic [0:id_width-1] rst_id_q;

   // one bit per context, set once the first reset of that id went through
   logic [0:n_ctx-1]    used_q;

   // high in the cycle right after a transfer
   logic                gap_q;

   logic                rst_sup;
   logic                rst_cand;
   logic [0:op_w-1]     gnt;
   logic                xfer;

   // a latched reset to an id that is already in use gets acked and dropped
   assign rst_sup  = rst_v_q & used_q[rst_id_q];
   assign rst_cand = rst_v_q & ~used_q[rst_id_q];

   // fixed priority, increment first, then reset, then decrement
   always_comb begin
      gnt = '0;
      if (inc_v_q) begin
         gnt[op_inc] = 1'b1;
      end else if (rst_cand) begin
         gnt[op_rst] = 1'b1;
      end else if (i_dec_v) begin
         gnt[op_dec] = 1'b1;
      end
   end

   // the id follows the granted source
   always_comb begin
      if (gnt[op_inc]) begin
         o_req.id = inc_id_q;
      end else if (gnt[op_rst]) begin
         o_req.id = rst_id_q;
      end else begin
         o_req.id = i_dec_id;
      end
   end

   // nothing is offered in the gap cycle, which keeps the table read of the
   // next transaction clear of the write-back of the last one
   assign o_req.valid    = (|gnt) & ~gap_q;
   assign o_req.sel      = gnt;
   assign o_req.frc_oflw = gnt[op_inc] & inc_frc_q;

   assign xfer = o_req.valid & o_req.ready;

   // a new increment may only arrive while the latch is empty
   assign o_inc_rdy = ~inc_v_q;

   // decrement has the lowest priority, so it is only ready when neither
   // latch competes and the stage can take a request this cycle
   assign o_dec_r = o_req.ready & ~gap_q & ~inc_v_q & ~rst_cand;

   // ack either on the transfer of a first reset or straight away for a repeat
   assign o_rst_ack = rst_sup | (xfer & gnt[op_rst]);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         inc_v_q <= 1'b0;
         rst_v_q <= 1'b0;
         used_q  <= '0;
         gap_q   <= 1'b0;
      end else begin
         gap_q <= xfer;

         // the latch empties when its increment wins, i_inc_v is illegal then
         if (i_inc_v) begin
            inc_v_q <= 1'b1;
         end else if (xfer && gnt[op_inc]) begin
            inc_v_q <= 1'b0;
         end

         // the requester waits for o_rst_ack before it sends the next reset,
         // a reset arriving on the ack cycle refills the latch
         if (o_rst_ack) begin
            rst_v_q <= 1'b0;
         end
         if (i_rst_v) begin
            rst_v_q <= 1'b1;
         end

         // first use is recorded when the reset actually goes to the table
         if (xfer && gnt[op_rst]) begin
            used_q[rst_id_q] <= 1'b1;
         end
      end
   end

   // latch payloads, only meaningful while the matching valid is set
   always_ff @(posedge clk) begin
      if (i_inc_v) begin
         inc_id_q  <= i_inc_id;
         inc_frc_q <= i_inc_frc_oflw;
      end
      if (i_rst_v) begin
         rst_id_q <= i_rst_id;
      end
   end

endmodule : ctx_req_arb

`default_nettype wire

// File: rtl/ctx_cnt_stage.sv
`timescale 1ns/1ps
`default_nettype none

// read-modify-write stage of the counter pipeline
// the table is read on the transfer edge, and one cycle later the new value
// is written back unless the operation overflows or underflows
module ctx_cnt_stage #(
   parameter int id_width  = ctx_cnt_pkg::def_id_width,
   parameter int cnt_width = ctx_cnt_pkg::def_cnt_width
) (
   input  wire                 clk,
   input  wire                 i_rst_n,

   ctx_req_if.dst              i_req,

   input  wire [0:cnt_width-1] i_maxv,

   input  wire                 i_inc_r,
   output logic                o_inc_v,
   output logic                o_inc_err,

   output logic                o_we,
   output logic [0:id_width-1] o_wa,
   output logic [0:cnt_width-1] o_wd
);
   import ctx_cnt_pkg::*;

   localparam int n_ctx = 2 ** id_width;
   localparam logic [0:cnt_width-1] cnt_one = cnt_width'(1);

   // the counter table itself
   logic [0:cnt_width-1] mem_q [0:n_ctx-1];

   // item held in the stage
   logic                 hold_v_q;
   logic                 first_q;
   logic [0:op_w-1]      sel_q;
   logic [0:id_width-1]  id_q;
   logic                 frc_q;
   logic [0:cnt_width-1] cnt_q;

   logic                 xfer;
   logic                 oflw;
   logic                 uflw;
   logic                 wb_sup;
   logic [0:cnt_width-1] wd;

   // only an increment waits on its consumer, resets and decrements
   // leave after a single cycle
   assign i_req.ready = ~hold_v_q | ~sel_q[op_inc] | i_inc_r;

   assign xfer = i_req.valid & i_req.ready;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         hold_v_q <= 1'b0;
         first_q  <= 1'b0;
      end else begin
         // when ready is high the held item leaves and a new one may come in
         if (i_req.ready) begin
            hold_v_q <= i_req.valid;
         end
         // marks the one cycle where the write-back of the held item happens
         first_q <= xfer;
      end
   end

   // request payload and the counter read, both taken on the transfer edge
   always_ff @(posedge clk) begin
      if (xfer) begin
         sel_q <= i_req.sel;
         id_q  <= i_req.id;
         frc_q <= i_req.frc_oflw;
         cnt_q <= mem_q[i_req.id];
      end
   end

   // an increment at the limit or with forced overflow does not count
   assign oflw = sel_q[op_inc] & (frc_q | (cnt_q == i_maxv));

   // a decrement of an empty counter leaves it at zero
   assign uflw = sel_q[op_dec] & (cnt_q == '0);

   assign wb_sup = oflw | uflw;

   // new value chosen by the one-hot select, reset writes zero
   always_comb begin
      if (sel_q[op_inc]) begin
         wd = cnt_q + cnt_one;
      end else if (sel_q[op_dec]) begin
         wd = cnt_q - cnt_one;
      end else begin
         wd = '0;
      end
   end

   // the gap in the arbiter keeps first_q a single-cycle pulse, so a held
   // increment is written only once however long the consumer stalls
   assign o_we = first_q & ~wb_sup;
   assign o_wa = id_q;
   assign o_wd = wd;

   always_ff @(posedge clk) begin
      if (o_we) begin
         mem_q[id_q] <= wd;
      end
   end

   // increment result stays up until the consumer takes it
   assign o_inc_v   = hold_v_q & sel_q[op_inc];
   assign o_inc_err = oflw;

endmodule : ctx_cnt_stage

`default_nettype wire

// File: rtl/ctx_cnt_shadow.sv
`timescale 1ns/1ps
`default_nettype none

// host-visible copy of the counter table
// every write of the update stage lands here as well, so a host read
// never has to touch the table inside the pipeline
module ctx_cnt_shadow #(
   parameter int id_width  = ctx_cnt_pkg::def_id_width,
   parameter int cnt_width = ctx_cnt_pkg::def_cnt_width
) (
   input  wire                  clk,

   input  wire                  i_we,
   input  wire [0:id_width-1]   i_wa,
   input  wire [0:cnt_width-1]  i_wd,

   input  wire                  i_rd_v,
   input  wire [0:id_width-1]   i_rd_id,
   output logic                 o_rd_v,
   output logic [0:cnt_width-1] o_rd_d
);

   localparam int n_ctx = 2 ** id_width;

   logic [0:cnt_width-1] shd_q [0:n_ctx-1];

   // mirror write, same address and data as the real table
   always_ff @(posedge clk) begin
      if (i_we) begin
         shd_q[i_wa] <= i_wd;
      end
   end

   // read result one cycle after the request
   // a read and a write to the same id in one cycle return the old count
   always_ff @(posedge clk) begin
      if (i_rd_v) begin
         o_rd_d <= shd_q[i_rd_id];
      end
   end

   // the valid simply follows the request, it goes low on its own
   // once the host holds i_rd_v low through reset
   always_ff @(posedge clk) begin
      o_rd_v <= i_rd_v;
   end

endmodule : ctx_cnt_shadow

`default_nettype wire

// File: rtl/ctx_cnt_top.sv
`timescale 1ns/1ps
`default_nettype none

// per-context usage counter
// arbiter in front, read-modify-write stage behind it, and a shadow copy
// of the table fed from the mirror write for host reads
module ctx_cnt_top #(
   parameter int id_width  = ctx_cnt_pkg::def_id_width,
   parameter int cnt_width = ctx_cnt_pkg::def_cnt_width
) (
   input  wire                  clk,
   input  wire                  i_rst_n,

   // reset request, acked once per request
   input  wire                  i_rst_v,
   input  wire [0:id_width-1]   i_rst_id,
   output wire                  o_rst_ack,

   // increment request
   input  wire                  i_inc_v,
   input  wire [0:id_width-1]   i_inc_id,
   input  wire                  i_inc_frc_oflw,
   output wire                  o_inc_rdy,

   // increment result
   input  wire                  i_inc_r,
   output wire                  o_inc_v,
   output wire                  o_inc_err,

   // decrement request
   input  wire                  i_dec_v,
   input  wire [0:id_width-1]   i_dec_id,
   output wire                  o_dec_r,

   // shared limit for every context
   input  wire [0:cnt_width-1]  i_maxv,

   // mirror of every table write
   output wire                  o_we,
   output wire [0:id_width-1]   o_wa,
   output wire [0:cnt_width-1]  o_wd,

   // host read of the shadow table
   input  wire                  i_rd_v,
   input  wire [0:id_width-1]   i_rd_id,
   output wire                  o_rd_v,
   output wire [0:cnt_width-1]  o_rd_d
);

   // request path between arbiter and update stage
   ctx_req_if #(.id_width(id_width)) req_if ();

   ctx_req_arb #(.id_width(id_width)) u_arb (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_rst_v(i_rst_v), .i_rst_id(i_rst_id), .o_rst_ack(o_rst_ack),
      .i_inc_v(i_inc_v), .i_inc_id(i_inc_id), .i_inc_frc_oflw(i_inc_frc_oflw),
      .o_inc_rdy(o_inc_rdy),
      .i_dec_v(i_dec_v), .i_dec_id(i_dec_id), .o_dec_r(o_dec_r),
      .o_req(req_if.src)
   );

   ctx_cnt_stage #(.id_width(id_width), .cnt_width(cnt_width)) u_stage (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_req(req_if.dst),
      .i_maxv(i_maxv),
      .i_inc_r(i_inc_r), .o_inc_v(o_inc_v), .o_inc_err(o_inc_err),
      .o_we(o_we), .o_wa(o_wa), .o_wd(o_wd)
   );

   // the shadow sees exactly the writes that leave the top
   ctx_cnt_shadow #(.id_width(id_width), .cnt_width(cnt_width)) u_shadow (
      .clk(clk),
      .i_we(o_we), .i_wa(o_wa), .i_wd(o_wd),
      .i_rd_v(i_rd_v), .i_rd_id(i_rd_id),
      .o_rd_v(o_rd_v), .o_rd_d(o_rd_d)
   );

endmodule : ctx_cnt_top

`default_nettype wire

// File: tb/ctx_cnt_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the per-context usage counter
// vectors run one after another, except the mix line, which puts an
// increment, a reset and a decrement on the ports in the same cycle
module ctx_cnt_tb;

   localparam int id_w     = 4;
   localparam int cnt_w    = 8;
   localparam int wait_lim = 100;

   // end markers an operation can wait for
   localparam int mk_ack  = 0;
   localparam int mk_res  = 1;
   localparam int mk_take = 2;
   localparam int mk_dec  = 3;
   localparam int mk_rd   = 4;

   logic             clk;
   logic             i_rst_n;
   logic             i_inc_r = 1'b0;
   logic             i_rst_v, i_inc_v, i_inc_frc_oflw, i_dec_v, i_rd_v;
   logic [id_w-1:0]  i_rst_id, i_inc_id, i_dec_id, i_rd_id, o_wa;
   logic [cnt_w-1:0] i_maxv, o_wd, o_rd_d;
   logic             o_rst_ack, o_inc_rdy, o_inc_v, o_inc_err, o_dec_r, o_we, o_rd_v;

   // vectors from the tests file
   string t_name[$];
   string t_op[$];
   int    t_id[$];
   int    t_exp[$];
   logic  loaded = 1'b0;

   // every table write seen at the top, kept by address
   int               we_cnt = 0;
   logic [cnt_w-1:0] last_wd [0:2**id_w-1];

   int          n_val_err;
   int          n_proto_err;
   logic        stall_hold;

   ctx_cnt_top #(.id_width(id_w), .cnt_width(cnt_w)) i_dut (.*);

   always #5 clk = ~clk;

   // consumer of increment results, it stalls about one cycle in four
   initial begin
      void'($urandom(32'h17e8eb6d));
      forever begin
         @(posedge clk);
         i_inc_r <= ~stall_hold & (($urandom % 4) != 0);
      end
   end

   // write monitor, sampled on the falling edge where the outputs are settled
   always @(negedge clk) begin
      if (o_we) begin
         we_cnt = we_cnt + 1;
         last_wd[o_wa] = o_wd;
      end
   end

   function automatic logic marker_seen(input int mk);
      case (mk)
         mk_ack:  return o_rst_ack;
         mk_res:  return o_inc_v;
         mk_take: return o_inc_v & i_inc_r;
         mk_dec:  return o_dec_r;
         default: return o_rd_v;
      endcase
   endfunction

   // entered on a falling edge, steps falling edges until the marker shows
   task automatic wait_marker(input string name, input int mk, input string what);
      int k;
      k = 0;
      while (!marker_seen(mk) && k < wait_lim) begin
         @(negedge clk);
         k++;
      end
      assert (marker_seen(mk)) else begin
         $display("test %s: %s did not arrive within %0d cycles", name, what, wait_lim);
         n_proto_err++;
      end
   endtask

   task automatic check_val(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         $display("FAILED %s: %s expected %0d, actual %0d", name, what, exp, got);
         n_val_err++;
      end
   endtask

   // the write-back comes one cycle after the transfer, so a short window
   // after the last expected write also catches a write that must not happen
   task automatic check_writes(input string name, input int start, input int n_exp);
      int k;
      k = 0;
      while (we_cnt - start < n_exp && k < wait_lim) begin
         @(posedge clk);
         k++;
      end
      repeat (3) @(posedge clk);
      check_val(name, "table writes", n_exp, we_cnt - start);
   endtask

   task automatic send_rst(input string name, input int id);
      @(posedge clk);
      i_rst_v  <= 1'b1;
      i_rst_id <= id[id_w-1:0];
      @(posedge clk);
      i_rst_v <= 1'b0;
      @(negedge clk);
      wait_marker(name, mk_ack, "reset acknowledge");
   endtask

   // returns the error flag seen with the first cycle of the result
   task automatic send_inc(input string name, input int id, input logic frc,
                           output logic err);
      @(posedge clk);
      i_inc_v        <= 1'b1;
      i_inc_id       <= id[id_w-1:0];
      i_inc_frc_oflw <= frc;
      @(negedge clk);
      // a request may only be presented while the latch is empty
      check_val(name, "increment ready on request", 1, 32'(o_inc_rdy));
      @(posedge clk);
      i_inc_v <= 1'b0;
      @(negedge clk);
      // the latch keeps the request until it wins arbitration
      check_val(name, "increment ready while latched", 0, 32'(o_inc_rdy));
      wait_marker(name, mk_res, "increment result");
      err = o_inc_err;
      wait_marker(name, mk_take, "increment result handshake");
   endtask

   // the decrement is held until the DUT raises o_dec_r
   task automatic send_dec(input string name, input int id);
      @(posedge clk);
      i_dec_v  <= 1'b1;
      i_dec_id <= id[id_w-1:0];
      @(negedge clk);
      wait_marker(name, mk_dec, "decrement ready");
      @(posedge clk);
      i_dec_v <= 1'b0;
   endtask

   task automatic read_check(input string name, input int id, input int exp);
      @(posedge clk);
      i_rd_v  <= 1'b1;
      i_rd_id <= id[id_w-1:0];
      @(posedge clk);
      i_rd_v <= 1'b0;
      @(negedge clk);
      wait_marker(name, mk_rd, "read result");
      check_val(name, "count", exp, 32'(o_rd_d));
      // the last write seen at the top for this id carries the same count
      check_val(name, "last written value", exp, 32'(last_wd[id[id_w-1:0]]));
   endtask

   initial begin
      int    fd;
      int    t;
      int    id;
      int    exp_v;
      int    start;
      string line;
      string name;
      string op;
      logic  err;
      clk = 1'b0;
      stall_hold = 1'b0;
      n_val_err = 0;
      n_proto_err = 0;
      i_rst_n <= 1'b0;
      i_rst_v <= 1'b0;
      i_rst_id <= '0;
      i_inc_v <= 1'b0;
      i_inc_id <= '0;
      i_inc_frc_oflw <= 1'b0;
      i_dec_v <= 1'b0;
      i_dec_id <= '0;
      i_maxv <= 8'd3;
      i_rd_v <= 1'b0;
      i_rd_id <= '0;
      fd = $fopen("tb/ctx_cnt_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file tb/ctx_cnt_tests.txt");
         n_proto_err++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            // lines starting with # are comments
            if (line[0] != "#" && $sscanf(line, "%s %s %d %d", name, op, id, exp_v) == 4) begin
               t_name.push_back(name);
               t_op.push_back(op);
               t_id.push_back(id);
               t_exp.push_back(exp_v);
            end
         end
         $fclose(fd);
      end
      if (t_name.size() == 0) begin
         $display("no test vectors were loaded");
         n_proto_err++;
      end
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      i_rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (t = 0; t < t_name.size(); t++) begin
         name  = t_name[t];
         start = we_cnt;
         if (t_op[t] == "rst") begin
            send_rst(name, t_id[t]);
            check_writes(name, start, t_exp[t]);
         end else if (t_op[t] == "inc" || t_op[t] == "incf") begin
            send_inc(name, t_id[t], t_op[t] == "incf", err);
            check_val(name, "error flag", t_exp[t], 32'(err));
            // an increment that overflows leaves the table alone
            check_writes(name, start, (t_exp[t] != 0) ? 0 : 1);
         end else if (t_op[t] == "dec") begin
            send_dec(name, t_id[t]);
            check_writes(name, start, t_exp[t]);
         end else if (t_op[t] == "rd") begin
            read_check(name, t_id[t], t_exp[t]);
         end else if (t_op[t] == "mix") begin
            @(negedge clk);
            stall_hold = 1'b1;
            fork
               send_inc(name, t_id[t], 1'b0, err);
               send_rst(name, t_id[t] + 1);
               send_dec(name, t_id[t] + 2);
               begin
                  // keep the result stalled so the reset queues up behind it
                  @(posedge o_inc_v);
                  repeat (6) @(negedge clk);
                  stall_hold = 1'b0;
               end
            join
            check_writes(name, start, t_exp[t]);
         end else begin
            $display("test %s: unknown operation %s", name, t_op[t]);
            n_proto_err++;
         end
      end
      $display("error counts: %0d value errors, %0d protocol errors", n_val_err, n_proto_err);
      if (n_val_err == 0 && n_proto_err == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // watchdog, 200 cycles for each vector plus some room for the reset
   initial begin
      int lim;
      wait (loaded === 1'b1);
      lim = 200 * t_name.size() + 50;
      repeat (lim) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", lim);
      $display("TESTS FAILED");
      $finish;
   end

endmodule : ctx_cnt_tb

`default_nettype wire

// File: tb/ctx_cnt_tests.txt
# columns: test name, operation, context id, expected value
# inc and incf expect the error flag, rd the count, rst and dec 1 on a table write, mix the writes
rst_first_a      rst  1  1
rd_after_rst     rd   1  0
inc_a_1          inc  1  0
inc_a_2          inc  1  0
rd_count_2       rd   1  2
rst_repeat_a     rst  1  0
rd_after_repeat  rd   1  2
inc_a_3          inc  1  0
inc_at_limit     inc  1  1
rd_at_limit      rd   1  3
incf_at_limit    incf 1  1
rst_first_b      rst  2  1
incf_at_zero     incf 2  1
rd_b_after_incf  rd   2  0
dec_b_at_zero    dec  2  0
rd_b_at_zero     rd   2  0
dec_a            dec  1  1
rd_a_after_dec   rd   1  2
rst_mix_inc      rst  8  1
rst_mix_dec      rst  10 1
inc_mix_dec      inc  10 0
mix_three        mix  8  3
rd_mix_inc       rd   8  1
rd_mix_rst       rd   9  0
rd_mix_dec       rd   10 0
rst_repeat_mix   rst  9  0
rd_mix_rst_again rd   9  0

// File: vlog.f
rtl/ctx_cnt_pkg.sv
rtl/ctx_req_if.sv
rtl/ctx_req_arb.sv
rtl/ctx_cnt_stage.sv
rtl/ctx_cnt_shadow.sv
rtl/ctx_cnt_top.sv
tb/ctx_cnt_tb.sv

// File: Bender.yml
package:
  name: ctx_cnt

sources:
  - files:
      - rtl/ctx_cnt_pkg.sv
      - rtl/ctx_req_if.sv
      - rtl/ctx_req_arb.sv
      - rtl/ctx_cnt_stage.sv
      - rtl/ctx_cnt_shadow.sv
      - rtl/ctx_cnt_top.sv
  - target: test
    files:
      - tb/ctx_cnt_tb.sv
